// File: Bender.yml
package:
  name: rvfi_trace_checker

sources:
  - design/rvfi_pkg.sv
  - design/checker_pkg.sv
  - design/rvfi_cause_checker.sv
  - design/mem_access_tracker.sv
  - design/violation_log.sv
  - design/axil_status_regs.sv
  - design/trace_checker_top.sv
  - target: test
    files:
      - test/trace_checker_properties.sv
      - test/tb_trace_checker.sv

// File: compile.f
design/rvfi_pkg.sv
design/checker_pkg.sv
design/rvfi_cause_checker.sv
design/mem_access_tracker.sv
design/violation_log.sv
design/axil_status_regs.sv
design/trace_checker_top.sv
test/trace_checker_properties.sv
test/tb_trace_checker.sv

// File: design/axil_status_regs.sv
// AXI4-Lite slave for the violation log.
// Reads return the flags, the counters and the first kind; writing bit 0
// of REG_CLEAR pulses clear. Unmapped addresses answer SLVERR.
`timescale 1ns/1ps

module axil_status_regs
  import checker_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  axil_req_t   axil_req,
  output axil_rsp_t   axil_rsp,
  input  log_status_t status,
  output logic        clear
);

  typedef enum logic {W_IDLE, W_RESP} wr_state_e;
  typedef enum logic {R_IDLE, R_RESP} rd_state_e;

  wr_state_e  wr_state;
  rd_state_e  rd_state;
  logic       wr_accept;
  logic       rd_accept;
  logic       wr_hit_clear;
  axil_data_t rd_data;
  axil_resp_t rd_resp;
  axil_resp_t bresp_q;
  axil_data_t rdata_q;
  axil_resp_t rresp_q;

  // Address and data are taken together, only while no response is held
  assign wr_accept    = (wr_state == W_IDLE) && axil_req.awvalid && axil_req.wvalid;
  assign rd_accept    = (rd_state == R_IDLE) && axil_req.arvalid;
  assign wr_hit_clear = axil_req.awaddr == REG_CLEAR;
  assign clear        = wr_accept && wr_hit_clear && axil_req.wdata[0];

  always_comb begin
    rd_data = '0;
    rd_resp = AXIL_OKAY;
    case (axil_req.araddr)
      REG_FLAGS:        rd_data = axil_data_t'(status.flags);
      REG_VIOL_COUNT:   rd_data = axil_data_t'(status.viol_count);
      REG_RETIRE_COUNT: rd_data = axil_data_t'(status.retire_count);
      REG_FIRST_KIND:   rd_data = axil_data_t'({status.first_valid, status.first_kind});
      REG_CLEAR:        rd_data = '0;
      default:          rd_resp = AXIL_SLVERR;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_state <= W_IDLE;
      rd_state <= R_IDLE;
    end else begin
      case (wr_state)
        W_IDLE: if (wr_accept) wr_state <= W_RESP;
        W_RESP: if (axil_req.bready) wr_state <= W_IDLE;
        default: wr_state <= W_IDLE;
      endcase
      case (rd_state)
        R_IDLE: if (rd_accept) rd_state <= R_RESP;
        R_RESP: if (axil_req.rready) rd_state <= R_IDLE;
        default: rd_state <= R_IDLE;
      endcase
    end
  end

  // Response payload, held until the master takes it
  always_ff @(posedge clk_i) begin
    if (wr_accept) begin
      bresp_q <= wr_hit_clear ? AXIL_OKAY : AXIL_SLVERR;
    end
    if (rd_accept) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp         = '0;
    axil_rsp.awready = wr_accept;
    axil_rsp.wready  = wr_accept;
    axil_rsp.bvalid  = wr_state == W_RESP;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = rd_accept;
    axil_rsp.rvalid  = rd_state == R_RESP;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

// File: design/checker_pkg.sv
// Checker-side definitions: violation kinds, the status register map and
// the AXI4-Lite request and response structs of the host port.
// Shared by the checkers, the violation log and the register slave.
package checker_pkg;

  localparam int NUM_VIOL = 6;

  // Encoding doubles as the bit index in viol_vec_t
  typedef enum logic [2:0] {
    DBG_CAUSE      = 3'd0,
    EXC_CAUSE      = 3'd1,
    IRQ_CAUSE      = 3'd2,
    MISSING_CAUSE  = 3'd3,
    HANDLER_ORDER  = 3'd4,
    MEM_OVERREPORT = 3'd5
  } viol_kind_e;

  typedef logic [NUM_VIOL-1:0] viol_vec_t;
  typedef logic [15:0]         count_t;
  typedef logic [7:0]          reg_addr_t;
  typedef logic [31:0]         axil_data_t;
  typedef logic [1:0]          axil_resp_t;

  localparam count_t COUNT_MAX = 16'hFFFF;

  // Register map
  localparam reg_addr_t REG_FLAGS        = 8'h00;
  localparam reg_addr_t REG_VIOL_COUNT   = 8'h04;
  localparam reg_addr_t REG_RETIRE_COUNT = 8'h08;
  localparam reg_addr_t REG_FIRST_KIND   = 8'h0C;
  localparam reg_addr_t REG_CLEAR        = 8'h10;

  localparam axil_resp_t AXIL_OKAY   = 2'd0;
  localparam axil_resp_t AXIL_SLVERR = 2'd2;

  typedef struct packed {
    reg_addr_t  awaddr;
    logic       awvalid;
    axil_data_t wdata;
    logic       wvalid;
    logic       bready;
    reg_addr_t  araddr;
    logic       arvalid;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

  typedef struct packed {
    viol_vec_t  flags;
    count_t     viol_count;
    count_t     retire_count;
    logic       first_valid;
    viol_kind_e first_kind;
  } log_status_t;

endpackage

// File: design/mem_access_tracker.sv
// Compares accepted write-buffer handshakes with the memory accesses that
// the trace reports. Raises MEM_OVERREPORT once when the trace gets ahead.
`timescale 1ns/1ps

module mem_access_tracker
  import rvfi_pkg::*;
  import checker_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      bus_valid,
  input  logic      bus_ready,
  input  rvfi_rec_t rvfi,
  input  logic      clear,
  output viol_vec_t viol
);

  logic [31:0] bus_cnt;
  logic [31:0] trace_cnt;
  logic [31:0] trace_inc;
  logic        over;
  logic        over_q;

  // Each record reports at most one read and one write
  assign trace_inc = rvfi.valid ? (32'(|rvfi.mem_rmask) + 32'(|rvfi.mem_wmask)) : 32'd0;
  assign over      = trace_cnt > bus_cnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_cnt   <= '0;
      trace_cnt <= '0;
      over_q    <= 1'b0;
      viol      <= '0;
    end else if (clear) begin
      bus_cnt   <= '0;
      trace_cnt <= '0;
      over_q    <= 1'b0;
      viol      <= '0;
    end else begin
      bus_cnt   <= bus_cnt + 32'(bus_valid && bus_ready);
      trace_cnt <= trace_cnt + trace_inc;
      over_q    <= over;
      viol      <= '0;
      viol[MEM_OVERREPORT] <= over && !over_q;
    end
  end

endmodule

// File: design/rvfi_cause_checker.sv
// Applies the per-record cause and handler-order rules to the RVFI stream.
// One viol bit per broken rule, registered, plus a retire pulse per record.
// Set CLIC to match the interrupt controller of the core under watch.
`timescale 1ns/1ps

module rvfi_cause_checker
  import rvfi_pkg::*;
  import checker_pkg::*;
#(
  parameter bit CLIC = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rvfi_rec_t rvfi,
  output viol_vec_t viol,
  output logic      retire
);

  localparam cause_t CLIC_MAX_ID = cause_t'((1 << CLIC_ID_WIDTH) - 1);

  logic      was_dbg_mode;
  logic      was_exception;
  xlen_t     mcause_masked;
  cause_t    exc_code;
  logic      dbg_entry;
  logic      irq_legal_clint;
  logic      irq_legal_clic;
  logic      irq_legal;
  viol_vec_t viol_d;

  // State of the previous retired record
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      was_dbg_mode  <= 1'b0;
      was_exception <= 1'b0;
    end else if (rvfi.valid) begin
      was_dbg_mode  <= rvfi.dbg_mode;
      was_exception <= rvfi.trap.exception;
    end
  end

  assign mcause_masked = rvfi.mcause_wdata & rvfi.mcause_wmask;
  assign exc_code      = mcause_masked[$bits(cause_t)-1:0];
  assign dbg_entry     = (rvfi.dbg != DBG_NONE) && !was_dbg_mode;

  assign irq_legal_clint = rvfi.intr.cause inside {11'd3, 11'd7, 11'd11, [11'd16:11'd31],
                                                   [NMI_CAUSE_LO:NMI_CAUSE_HI]};
  assign irq_legal_clic  = rvfi.intr.cause inside {[11'd0:CLIC_MAX_ID],
                                                   [NMI_CAUSE_LO:NMI_CAUSE_HI]};
  assign irq_legal       = CLIC ? irq_legal_clic : irq_legal_clint;

  always_comb begin
    viol_d = '0;
    if (rvfi.valid) begin
      viol_d[DBG_CAUSE] = dbg_entry && (rvfi.dbg != rvfi.dcsr_rdata[8:6]);
      // Exception writes its cause to mcause and clears mcause.interrupt
      viol_d[EXC_CAUSE] = rvfi.trap.exception && !rvfi.dbg_mode &&
                          ((exc_code != cause_t'(rvfi.trap.exception_cause)) ||
                           !rvfi.mcause_wmask[31] || rvfi.mcause_wdata[31]);
      viol_d[IRQ_CAUSE] = rvfi.intr.interrupt && !irq_legal;
      viol_d[MISSING_CAUSE] = (rvfi.trap.exception && (rvfi.trap.exception_cause == '0)) ||
                              (rvfi.trap.debug && (rvfi.trap.debug_cause == DBG_NONE)) ||
                              (!CLIC && rvfi.intr.interrupt && (rvfi.intr.cause == '0));
      // Ambiguous handler, or sync handler with no exception before it
      viol_d[HANDLER_ORDER] = (rvfi.intr.exception && rvfi.intr.interrupt) ||
                              (rvfi.intr.exception && !was_exception);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol   <= '0;
      retire <= 1'b0;
    end else begin
      viol   <= viol_d;
      retire <= rvfi.valid;
    end
  end

endmodule

// File: design/rvfi_pkg.sv
// Types for the RISC-V retirement trace (RVFI) as seen by the trace checker.
// Covers one retired record with a single memory lane and the trap and interrupt
// side-band fields. Import it wherever a record or a cause is handled.
package rvfi_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [10:0] cause_t;
  typedef logic [2:0]  dbg_cause_t;
  typedef logic [3:0]  byte_mask_t;

  // Debug causes, same encoding as dcsr.cause
  localparam dbg_cause_t DBG_NONE    = 3'd0;
  localparam dbg_cause_t DBG_EBREAK  = 3'd1;
  localparam dbg_cause_t DBG_TRIGGER = 3'd2;
  localparam dbg_cause_t DBG_HALTREQ = 3'd3;
  localparam dbg_cause_t DBG_STEP    = 3'd4;

  // CLIC interrupt IDs run from 0 to 2**CLIC_ID_WIDTH-1
  localparam int CLIC_ID_WIDTH = 5;

  // NMI causes are legal in both interrupt modes
  localparam cause_t NMI_CAUSE_LO = 11'd1024;
  localparam cause_t NMI_CAUSE_HI = 11'd1027;

  typedef struct packed {
    logic       exception;
    logic [5:0] exception_cause;
    logic       debug;
    dbg_cause_t debug_cause;
  } trap_t;

  typedef struct packed {
    logic   interrupt;
    logic   exception;
    cause_t cause;
  } intr_t;

  typedef struct packed {
    logic       valid;
    dbg_cause_t dbg;
    logic       dbg_mode;
    xlen_t      dcsr_rdata;
    xlen_t      mcause_wdata;
    xlen_t      mcause_wmask;
    trap_t      trap;
    intr_t      intr;
    byte_mask_t mem_rmask;
    byte_mask_t mem_wmask;
  } rvfi_rec_t;

endpackage

// File: design/trace_checker_top.sv
// Top of the RVFI trace checker.
// Cause rules and memory accounting feed the violation log, which the
// host reads and clears over AXI4-Lite. CLIC selects the interrupt mode.
`timescale 1ns/1ps

module trace_checker_top
  import rvfi_pkg::*;
  import checker_pkg::*;
#(
  parameter bit CLIC = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  rvfi_rec_t rvfi,
  input  logic      bus_valid,
  input  logic      bus_ready,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  output logic      irq_violation
);

  viol_vec_t   viol_cause;
  viol_vec_t   viol_mem;
  logic        retire;
  logic        clear;
  log_status_t status;

  rvfi_cause_checker #(
    .CLIC(CLIC)
  ) u_cause (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .rvfi  (rvfi),
    .viol  (viol_cause),
    .retire(retire)
  );

  mem_access_tracker u_mem (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .bus_valid(bus_valid),
    .bus_ready(bus_ready),
    .rvfi     (rvfi),
    .clear    (clear),
    .viol     (viol_mem)
  );

  violation_log u_log (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .viol_cause   (viol_cause),
    .viol_mem     (viol_mem),
    .retire       (retire),
    .clear        (clear),
    .status       (status),
    .irq_violation(irq_violation)
  );

  axil_status_regs u_regs (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .status  (status),
    .clear   (clear)
  );

endmodule

// File: design/violation_log.sv
// Sticky record of rule violations for the host.
// Holds one flag per kind, a saturating violation count, the retirement
// count and the first kind seen since reset or the last clear.
`timescale 1ns/1ps

module violation_log
  import checker_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  viol_vec_t   viol_cause,
  input  viol_vec_t   viol_mem,
  input  logic        retire,
  input  logic        clear,
  output log_status_t status,
  output logic        irq_violation
);

  viol_vec_t               viol_in;
  logic [2:0]              n_new;
  viol_kind_e              first_d;
  logic [$bits(count_t):0] viol_sum;
  viol_vec_t               flags_q;
  count_t                  viol_cnt_q;
  count_t                  retire_cnt_q;
  logic                    first_valid_q;
  viol_kind_e              first_kind_q;

  // Count the new kinds; scan downward so the lowest index ends up in first_d
  always_comb begin
    viol_in = viol_cause | viol_mem;
    n_new   = '0;
    first_d = DBG_CAUSE;
    for (int i = NUM_VIOL - 1; i >= 0; i--) begin
      if (viol_in[i]) begin
        n_new   = n_new + 3'd1;
        first_d = viol_kind_e'(i);
      end
    end
    viol_sum = {1'b0, viol_cnt_q} + ($bits(count_t) + 1)'(n_new);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flags_q       <= '0;
      viol_cnt_q    <= '0;
      retire_cnt_q  <= '0;
      first_valid_q <= 1'b0;
      first_kind_q  <= DBG_CAUSE;
    end else if (clear) begin
      flags_q       <= '0;
      viol_cnt_q    <= '0;
      retire_cnt_q  <= '0;
      first_valid_q <= 1'b0;
      first_kind_q  <= DBG_CAUSE;
    end else begin
      flags_q    <= flags_q | viol_in;
      viol_cnt_q <= viol_sum[$bits(count_t)] ? COUNT_MAX : viol_sum[$bits(count_t)-1:0];
      if (retire) begin
        retire_cnt_q <= retire_cnt_q + 16'd1;
      end
      if (!first_valid_q && (|viol_in)) begin
        first_valid_q <= 1'b1;
        first_kind_q  <= first_d;
      end
    end
  end

  assign status = '{flags:        flags_q,
                    viol_count:   viol_cnt_q,
                    retire_count: retire_cnt_q,
                    first_valid:  first_valid_q,
                    first_kind:   first_kind_q};

  assign irq_violation = |flags_q;

endmodule

// File: test/tb_trace_checker.sv
// Directed testbench for the RVFI trace checker in CLINT mode.
// Sends retirement records and bus handshakes, then reads the violation
// log over AXI4-Lite and compares it with the values the rules predict.
`timescale 1ns/1ps

module tb_trace_checker
  import rvfi_pkg::*;
  import checker_pkg::*;
();

  localparam int WAIT_LIMIT = 50;

  logic        clk_i;
  logic        rst_ni;
  rvfi_rec_t   rvfi;
  logic        bus_valid;
  logic        bus_ready;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        irq_violation;
  int          errors;
  int          timeouts;
  logic [31:0] rng_state;

  trace_checker_top #(
    .CLIC(1'b0)
  ) dut0 (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rvfi         (rvfi),
    .bus_valid    (bus_valid),
    .bus_ready    (bus_ready),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .irq_violation(irq_violation)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic rvfi_rec_t exc_record(input logic [5:0] code, input xlen_t mcause);
    rvfi_rec_t r;
    r = '0;
    r.valid = 1'b1;
    r.trap.exception = 1'b1;
    r.trap.exception_cause = code;
    r.mcause_wdata = mcause;
    r.mcause_wmask = '1;
    return r;
  endfunction

  function automatic rvfi_rec_t irq_record(input cause_t cause);
    rvfi_rec_t r;
    r = '0;
    r.valid = 1'b1;
    r.intr.interrupt = 1'b1;
    r.intr.cause = cause;
    return r;
  endfunction

  function automatic rvfi_rec_t debug_record(input dbg_cause_t cause, input dbg_cause_t dcsr);
    rvfi_rec_t r;
    r = '0;
    r.valid = 1'b1;
    r.dbg = cause;
    r.dcsr_rdata[8:6] = dcsr;
    r.trap.debug = 1'b1;
    r.trap.debug_cause = cause;
    return r;
  endfunction

  function automatic rvfi_rec_t handler_record(input logic irq, input logic exc);
    rvfi_rec_t r;
    r = '0;
    r.valid = 1'b1;
    r.intr.interrupt = irq;
    r.intr.exception = exc;
    r.intr.cause = 11'd3;
    return r;
  endfunction

  // Legal CLINT causes are 3, 7, 11, 16..31 and the four NMI causes
  function automatic cause_t clint_cause(input logic [31:0] r);
    int idx;
    idx = int'(r % 23);
    if (idx < 3) return cause_t'(3 + 4 * idx);
    if (idx < 19) return cause_t'(16 + idx - 3);
    return cause_t'(1024 + idx - 19);
  endfunction

  task automatic note_timeout(input string what);
    $display("timeout at %0t: %s never arrived", $time, what);
    timeouts++;
  endtask

  task automatic compare_viol(input viol_vec_t got, input viol_vec_t exp, input string name);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_count(input count_t got, input count_t exp, input string name);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_resp(input axil_resp_t got, input axil_resp_t exp, input string name);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_word(input axil_data_t got, input axil_data_t exp, input string name);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Bit 3 is the valid bit, bits 2 to 0 the kind
  task automatic compare_first(input axil_data_t got, input logic valid, input viol_kind_e kind);
    compare_word(got, axil_data_t'({valid, kind}), "first_kind");
  endtask

  // With hold above 0, bready stays low that many cycles after bvalid
  task automatic axil_write(input reg_addr_t addr, input axil_data_t data,
                            input int hold, output axil_resp_t resp);
    int n;
    @(posedge clk_i);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wvalid  <= 1'b1;
    axil_req.bready  <= (hold == 0);
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!axil_rsp.awready && n < WAIT_LIMIT);
    if (!axil_rsp.awready) begin
      note_timeout("write address ready");
    end else begin
      compare_bit(axil_rsp.wready, 1'b1, "wready with awready");
    end
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!axil_rsp.bvalid && n < WAIT_LIMIT);
    if (!axil_rsp.bvalid) note_timeout("write response");
    resp = axil_rsp.bresp;
    if (hold > 0) begin
      for (int i = 0; i < hold; i++) begin
        @(posedge clk_i);
        compare_bit(axil_rsp.bvalid, 1'b1, "bvalid while held");
      end
      axil_req.bready <= 1'b1;
      @(posedge clk_i);
    end
    axil_req.bready <= 1'b0;
  endtask

  // With hold above 0, rready stays low that many cycles after rvalid
  task automatic axil_read(input reg_addr_t addr, input int hold,
                           output axil_data_t data, output axil_resp_t resp);
    int n;
    @(posedge clk_i);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    axil_req.rready  <= (hold == 0);
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!axil_rsp.arready && n < WAIT_LIMIT);
    if (!axil_rsp.arready) note_timeout("read address ready");
    axil_req.arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!axil_rsp.rvalid && n < WAIT_LIMIT);
    if (!axil_rsp.rvalid) note_timeout("read response");
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    if (hold > 0) begin
      for (int i = 0; i < hold; i++) begin
        @(posedge clk_i);
        compare_bit(axil_rsp.rvalid, 1'b1, "rvalid while held");
        compare_word(axil_rsp.rdata, data, "rdata while held");
      end
      axil_req.rready <= 1'b1;
      @(posedge clk_i);
    end
    axil_req.rready <= 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t addr, output axil_data_t data);
    axil_resp_t resp;
    axil_read(addr, 0, data, resp);
    compare_resp(resp, AXIL_OKAY, "rresp");
  endtask

  task automatic send_record(input rvfi_rec_t rec);
    @(posedge clk_i);
    rvfi <= rec;
  endtask

  // Idle the trace long enough for a violation to reach the log
  task automatic settle(input int cycles);
    @(posedge clk_i);
    rvfi      <= '0;
    bus_valid <= 1'b0;
    bus_ready <= 1'b0;
    repeat (cycles) @(posedge clk_i);
  endtask

  task automatic clear_log();
    axil_resp_t resp;
    axil_write(REG_CLEAR, 32'h1, 0, resp);
    compare_resp(resp, AXIL_OKAY, "bresp");
  endtask

  task automatic check_log(input viol_vec_t flags, input count_t viol_count);
    axil_data_t data;
    read_reg(REG_FLAGS, data);
    compare_viol(viol_vec_t'(data), flags, "flags");
    read_reg(REG_VIOL_COUNT, data);
    compare_count(count_t'(data), viol_count, "viol_count");
  endtask

  task automatic test_reset_and_legal();
    axil_data_t data;
    read_reg(REG_FLAGS, data);
    compare_word(data, '0, "flags after reset");
    read_reg(REG_VIOL_COUNT, data);
    compare_word(data, '0, "viol_count after reset");
    read_reg(REG_RETIRE_COUNT, data);
    compare_word(data, '0, "retire_count after reset");
    read_reg(REG_FIRST_KIND, data);
    compare_word(data, '0, "first_kind after reset");
    read_reg(REG_CLEAR, data);
    compare_word(data, '0, "clear register");
    for (int i = 0; i < 20; i++) begin
      rng_state = xorshift32(rng_state);
      case (i % 3)
        0: send_record(exc_record(6'(1 + rng_state % 63), xlen_t'(1 + rng_state % 63)));
        1: send_record(irq_record(clint_cause(rng_state)));
        default: send_record(debug_record(dbg_cause_t'(1 + rng_state % 4),
                                          dbg_cause_t'(1 + rng_state % 4)));
      endcase
    end
    settle(3);
    check_log('0, 16'd0);
    read_reg(REG_RETIRE_COUNT, data);
    compare_count(count_t'(data), 16'd20, "retire_count");
    clear_log();
  endtask

  task automatic test_cause_mismatch();
    viol_vec_t  exp;
    axil_data_t data;
    exp = '0;
    exp[DBG_CAUSE] = 1'b1;
    exp[EXC_CAUSE] = 1'b1;
    send_record(debug_record(DBG_EBREAK, DBG_STEP));
    send_record(exc_record(6'd2, 32'd5));
    settle(3);
    check_log(exp, 16'd2);
    read_reg(REG_FIRST_KIND, data);
    compare_first(data, 1'b1, DBG_CAUSE);
    clear_log();
  endtask

  task automatic test_illegal_missing();
    viol_vec_t exp;
    exp = '0;
    exp[IRQ_CAUSE] = 1'b1;
    exp[MISSING_CAUSE] = 1'b1;
    send_record(irq_record(11'd12));
    send_record(exc_record(6'd0, 32'd0));
    settle(3);
    check_log(exp, 16'd2);
    clear_log();
  endtask

  task automatic test_handler_order();
    viol_vec_t exp;
    exp = '0;
    exp[HANDLER_ORDER] = 1'b1;
    send_record(handler_record(1'b1, 1'b1));
    send_record(handler_record(1'b0, 1'b0));
    send_record(handler_record(1'b0, 1'b1));
    // Sync handler right after an exception is legal
    send_record(exc_record(6'd4, 32'd4));
    send_record(handler_record(1'b0, 1'b1));
    settle(3);
    check_log(exp, 16'd2);
    clear_log();
  endtask

  task automatic test_mem_accounting();
    viol_vec_t exp;
    rvfi_rec_t rec;
    exp = '0;
    exp[MEM_OVERREPORT] = 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      bus_valid <= 1'b1;
      bus_ready <= 1'b1;
    end
    @(posedge clk_i);
    bus_valid <= 1'b0;
    bus_ready <= 1'b0;
    rec = handler_record(1'b0, 1'b0);
    rec.mem_wmask = 4'hF;
    repeat (3) send_record(rec);
    settle(3);
    check_log('0, 16'd0);
    rec.mem_wmask = 4'h0;
    rec.mem_rmask = 4'h3;
    send_record(rec);
    settle(3);
    check_log(exp, 16'd1);
    clear_log();
  endtask

  task automatic test_register_protocol();
    viol_vec_t  exp;
    axil_data_t data;
    axil_resp_t resp;
    exp = '0;
    exp[IRQ_CAUSE] = 1'b1;
    axil_read(8'h14, 0, data, resp);
    compare_resp(resp, AXIL_SLVERR, "rresp unmapped");
    compare_word(data, '0, "rdata unmapped");
    send_record(irq_record(11'd12));
    settle(3);
    compare_bit(irq_violation, 1'b1, "irq_violation");
    // Unmapped write is refused and leaves the log alone
    axil_write(8'h14, 32'h1, 3, resp);
    compare_resp(resp, AXIL_SLVERR, "bresp unmapped");
    compare_bit(irq_violation, 1'b1, "irq_violation after unmapped write");
    axil_read(REG_FLAGS, 5, data, resp);
    compare_resp(resp, AXIL_OKAY, "rresp held");
    compare_viol(viol_vec_t'(data), exp, "flags held");
    clear_log();
    settle(1);
    compare_bit(irq_violation, 1'b0, "irq_violation after clear");
    check_log('0, 16'd0);
    read_reg(REG_RETIRE_COUNT, data);
    compare_count(count_t'(data), 16'd0, "retire_count after clear");
    read_reg(REG_FIRST_KIND, data);
    compare_first(data, 1'b0, DBG_CAUSE);
  endtask

  initial begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    rvfi      = '0;
    bus_valid = 1'b0;
    bus_ready = 1'b0;
    axil_req  = '0;
    errors    = 0;
    timeouts  = 0;
    rng_state = 32'd15;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    test_reset_and_legal();
    test_cause_mismatch();
    test_illegal_missing();
    test_handler_order();
    test_mem_accounting();
    test_register_protocol();
    $display("run complete: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: test/trace_checker_properties.sv
// Concurrent assertions on the status register slave.
// Bound into axil_status_regs; checks response hold and the clear path.
`timescale 1ns/1ps

module trace_checker_properties
  import checker_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input axil_req_t   axil_req,
  input axil_rsp_t   axil_rsp,
  input log_status_t status,
  input logic        clear
);

  // Write response waits for bready
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

  // Read response and its data hold until rready
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else $error("read response changed before rready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear |=> status.flags == '0)
    else $error("flags still set after clear");

endmodule

bind axil_status_regs trace_checker_properties props0 (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .axil_req(axil_req),
  .axil_rsp(axil_rsp),
  .status  (status),
  .clear   (clear)
);
